// ==== logic/nes_consts.svh ====
`ifndef NES_CONSTS_SVH
`define NES_CONSTS_SVH

// Master clock dividers
`define NES_CPU_DIV        12      // Master clocks per CPU cycle
`define NES_PPU_DIV        4       // Master clocks per PPU cycle
`define NES_CPU_DIV_W      5       // Width of the CPU divider
`define NES_PPU_DIV_W      3       // Width of the PPU divider
`define NES_PAL_GROUP      5       // CPU cycles per PAL stretch group
`define NES_PAL_GROUP_W    3

// CPU bus widths
`define NES_ADDR_W         16
`define NES_DATA_W         8
`define NES_JOY_BITS       5       // Serial bits visible per joypad read

// Fixed CPU addresses
`define NES_OAM_DATA_ADDR  16'h2004  // Sprite DMA write target
`define NES_OAM_DMA_ADDR   16'h4014  // Write here starts sprite DMA
`define NES_JOY1_ADDR      16'h4016
`define NES_JOY2_ADDR      16'h4017

// Register window, upper bound exclusive
`define NES_REG_LO         16'h2000
`define NES_REG_HI         16'h4020

// APB side
`define NES_APB_AW         8
`define NES_APB_DW         32
`define NES_APB_CTRL       8'h00     // System type, read/write
`define NES_APB_STATUS     8'h04     // DMA status, read only

`endif

// ==== logic/nes_pkg.sv ====
`default_nettype none

`include "nes_consts.svh"

package nes_pkg;

	// Dendy shares the NTSC timing here, only bit 0 selects PAL
	typedef enum logic [1:0] {
		SYS_NTSC  = 2'd0,
		SYS_PAL   = 2'd1,
		SYS_DENDY = 2'd2
	} sys_type_e;

	typedef struct packed {
		logic [7:0] page;    // High byte, loaded by the 0x4014 write
		logic [7:0] offset;  // Low byte, counts through the page
	} bus_page_t;

	// One address word, decoded whole or as page plus offset
	typedef union packed {
		logic [`NES_ADDR_W-1:0] word;
		bus_page_t              paged;
	} bus_addr_u;

	typedef struct packed {
		bus_addr_u              addr;
		logic                   rnw;   // 1 read, 0 write
		logic [`NES_DATA_W-1:0] dout;
	} cpu_bus_t;

	typedef struct packed {
		bus_addr_u              addr;
		logic                   read;   // One clock strobe at cart_ce
		logic                   write;
		logic [`NES_DATA_W-1:0] dout;
	} mem_bus_t;

	typedef struct packed {
		bus_addr_u              addr;
		logic                   enable;  // DMA owns the bus this cycle
		logic                   read;    // Else a write
		logic [`NES_DATA_W-1:0] dout;
	} dma_req_t;

	typedef struct packed {
		logic cpu_ce;
		logic ppu_ce;
		logic cart_ce;
		logic odd_cycle;  // 1 on odd CPU cycles
	} clk_en_t;

	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`NES_APB_AW-1:0] paddr;
		logic [`NES_APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`NES_APB_DW-1:0] prdata;
		logic                   pready;
		logic                   pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic       sprite_busy;
		logic       dmc_active;
		logic [7:0] page;  // Source page of the last sprite DMA
	} dma_status_t;

endpackage

`default_nettype wire

// ==== logic/nes_clock_enables.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nes_consts.svh"

// Master clock to CPU/PPU enables
// Cyc  123456789ABC
// CPU  -----------C
// PPU  ---P---P---P
module nes_clock_enables (
	input  logic               clk,
	input  logic               reset,
	input  nes_pkg::sys_type_e sys_type,
	output nes_pkg::clk_en_t   ce
);

	logic [`NES_CPU_DIV_W-1:0]   div_cpu;
	logic [`NES_PPU_DIV_W-1:0]   div_ppu;
	logic [1:0]                  ppu_tick;   // PPU ticks seen in this CPU cycle
	logic [`NES_PAL_GROUP_W-1:0] group_cnt;  // Position in the PAL group
	logic                        stretched;  // Extra clock already taken
	logic                        odd_q;
	nes_pkg::sys_type_e          sys_q;      // Latched system type
	logic                        cpu_ce;
	logic                        ppu_ce;
	logic                        pal;
	logic                        realign;
	logic                        freeze;

	assign cpu_ce  = (div_cpu == `NES_CPU_DIV_W'(`NES_CPU_DIV));
	assign ppu_ce  = (div_ppu == `NES_PPU_DIV_W'(`NES_PPU_DIV));
	assign pal     = (sys_q == nes_pkg::SYS_PAL);
	assign realign = (sys_q != sys_type);  // Type changed, restart both dividers

	// Last cycle of a PAL group holds the CPU divider one clock
	assign freeze = pal && !stretched && (div_cpu == `NES_CPU_DIV_W'(1)) &&
		(group_cnt == `NES_PAL_GROUP_W'(`NES_PAL_GROUP - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu   <= `NES_CPU_DIV_W'(1);
			div_ppu   <= `NES_PPU_DIV_W'(1);
			ppu_tick  <= 2'd0;
			group_cnt <= '0;
			stretched <= 1'b0;
			odd_q     <= 1'b1;  // First CPU cycle is odd
			sys_q     <= nes_pkg::SYS_NTSC;
		end else begin
			sys_q <= sys_type;
			if (realign) begin
				div_cpu   <= `NES_CPU_DIV_W'(1);
				div_ppu   <= `NES_PPU_DIV_W'(1);
				ppu_tick  <= 2'd0;
				group_cnt <= '0;
				stretched <= 1'b0;
			end else begin
				if (!freeze)
					div_cpu <= cpu_ce ? `NES_CPU_DIV_W'(1) : div_cpu + `NES_CPU_DIV_W'(1);
				div_ppu <= ppu_ce ? `NES_PPU_DIV_W'(1) : div_ppu + `NES_PPU_DIV_W'(1);

				// Tick count restarts with every CPU cycle
				if (cpu_ce)
					ppu_tick <= 2'd0;
				else if (ppu_ce)
					ppu_tick <= ppu_tick + 2'd1;

				if (freeze)
					stretched <= 1'b1;
				else if (cpu_ce)
					stretched <= 1'b0;

				if (cpu_ce && pal) begin
					if (group_cnt == `NES_PAL_GROUP_W'(`NES_PAL_GROUP - 1))
						group_cnt <= '0;
					else
						group_cnt <= group_cnt + `NES_PAL_GROUP_W'(1);
				end
			end
			if (cpu_ce)
				odd_q <= ~odd_q;
		end
	end

	assign ce.cpu_ce    = cpu_ce;
	assign ce.ppu_ce    = ppu_ce;
	assign ce.cart_ce   = ppu_ce && (ppu_tick == 2'd0);  // First PPU tick with CPU data on the bus
	assign ce.odd_cycle = odd_q;

endmodule

`default_nettype wire

// ==== logic/nes_sprite_dmc_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nes_consts.svh"

// Sprite DMA reads on even cycles and writes 0x2004 on odd ones
// A DMC fetch steals one even cycle and the odd cycle after it idles
module nes_sprite_dmc_dma (
	input  logic                   clk,
	input  logic                   reset,
	input  nes_pkg::clk_en_t       ce,
	input  nes_pkg::bus_addr_u     bus_addr,
	input  logic                   bus_write,
	input  logic                   cpu_rnw,
	input  logic [`NES_DATA_W-1:0] cpu_dout,
	input  logic [`NES_DATA_W-1:0] from_data_bus,
	input  logic                   dmc_request,
	input  nes_pkg::bus_addr_u     dmc_addr,
	output nes_pkg::dma_req_t      dma,
	output logic                   pause_cpu,
	output logic                   dmc_ack,
	output nes_pkg::dma_status_t   status
);

	logic                   dmc_state;       // DMC fetch pending or in progress
	logic [1:0]             spr_state;       // 0 idle, 1 CPU held, 3 transferring
	nes_pkg::bus_addr_u     spr_src;         // Page and running offset
	logic [`NES_DATA_W-1:0] spr_byte;        // Byte on its way to OAM
	logic [8:0]             next_offset;     // Carry out ends the page
	logic                   sprite_trigger;
	logic                   odd;

	assign odd            = ce.odd_cycle;
	assign sprite_trigger = bus_write && (bus_addr.word == `NES_OAM_DMA_ADDR);
	assign next_offset    = {1'b0, spr_src.paged.offset} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state    <= 1'b0;
			spr_state    <= 2'd0;
			spr_src.word <= '0;
		end else if (ce.cpu_ce) begin
			// DMC is accepted on an even read cycle, served on the next even one
			if (!dmc_state && dmc_request && cpu_rnw && !odd)
				dmc_state <= 1'b1;
			if (dmc_state && !odd)
				dmc_state <= 1'b0;

			if (sprite_trigger) begin
				spr_src.paged.page   <= cpu_dout;
				spr_src.paged.offset <= 8'h00;
				spr_state            <= 2'd1;
			end
			if (spr_state == 2'd1 && cpu_rnw && odd)
				spr_state <= 2'd3;  // Aligned, first read comes next
			if (spr_state[1] && !odd && dmc_state)
				spr_state <= 2'd1;  // DMC took this slot, realign on the idle odd
			if (spr_state[1] && odd) begin
				spr_src.paged.offset <= next_offset[7:0];
				if (next_offset[8])
					spr_state <= 2'd0;  // Page done
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ce.cpu_ce && spr_state[1] && !odd)
			spr_byte <= from_data_bus;
	end

	assign dmc_ack   = dmc_state && !odd;
	assign pause_cpu = spr_state[0] || dmc_request;  // Held as long as either wants the bus

	assign dma.enable = dmc_ack || spr_state[1];
	assign dma.read   = !odd;
	assign dma.dout   = spr_byte;
	assign dma.addr   = dmc_ack ? dmc_addr :
		!odd ? spr_src : nes_pkg::bus_addr_u'(`NES_OAM_DATA_ADDR);

	assign status.sprite_busy = (spr_state != 2'd0);
	assign status.dmc_active  = dmc_state;
	assign status.page        = spr_src.paged.page;

endmodule

`default_nettype wire

// ==== logic/nes_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nes_consts.svh"

module nes_bus_arbiter (
	input  logic                     clk,
	input  logic                     reset,
	input  nes_pkg::clk_en_t         ce,
	input  nes_pkg::cpu_bus_t        cpu,
	input  nes_pkg::dma_req_t        dma,
	input  logic [`NES_DATA_W-1:0]   mem_din,
	input  logic [`NES_JOY_BITS-1:0] joypad1_data,
	input  logic [`NES_JOY_BITS-1:0] joypad2_data,
	output nes_pkg::bus_addr_u       bus_addr,
	output logic                     bus_write,
	output nes_pkg::mem_bus_t        mem,
	output logic [`NES_DATA_W-1:0]   from_data_bus,
	output logic [2:0]               joypad_out,
	output logic [1:0]               joypad_clock
);

	logic                   bus_read;
	logic [`NES_DATA_W-1:0] bus_dout;
	logic                   in_window;   // 0x2000 through 0x401F
	logic                   joy1_sel;
	logic                   joy2_sel;
	logic [`NES_DATA_W-1:0] open_bus;    // Last byte seen on the data bus
	logic [2:0]             joy_strobe;

	// Owner select, DMA wins whenever it asks
	assign bus_addr  = dma.enable ? dma.addr : cpu.addr;
	assign bus_read  = dma.enable ? dma.read : cpu.rnw;
	assign bus_write = !bus_read;
	assign bus_dout  = dma.enable ? dma.dout : cpu.dout;

	assign in_window = (bus_addr.word >= `NES_REG_LO) && (bus_addr.word < `NES_REG_HI);
	assign joy1_sel  = (bus_addr.word == `NES_JOY1_ADDR);
	assign joy2_sel  = (bus_addr.word == `NES_JOY2_ADDR);

	// Memory only sees reads outside the window
	assign mem.addr  = bus_addr;
	assign mem.read  = bus_read && ce.cart_ce && !in_window;
	assign mem.write = bus_write && ce.cart_ce;
	assign mem.dout  = bus_dout;

	// Data bus seen by the CPU and the DMA latch
	always_comb begin
		if (joy1_sel)
			from_data_bus = {open_bus[7:5], joypad1_data};
		else if (joy2_sel)
			from_data_bus = {open_bus[7:5], joypad2_data};
		else if (in_window)
			from_data_bus = open_bus;  // Nothing drives the bus
		else
			from_data_bus = mem_din;
	end

	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else
			open_bus <= from_data_bus;  // Floating bus keeps its charge
	end

	// Strobe lines to both joypads, set by writes to 0x4016
	always_ff @(posedge clk) begin
		if (reset)
			joy_strobe <= 3'd0;
		else if (joy1_sel && bus_write && ce.cart_ce)
			joy_strobe <= bus_dout[2:0];
	end

	assign joypad_out   = joy_strobe;
	assign joypad_clock = {joy2_sel && bus_read && ce.cart_ce,  // One pulse per port read
		joy1_sel && bus_read && ce.cart_ce};

endmodule

`default_nettype wire

// ==== logic/nes_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nes_consts.svh"

// APB slave, zero wait states
// CTRL holds the system type, STATUS mirrors the DMA block
module nes_config_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  nes_pkg::apb_req_t    apb_req,
	output nes_pkg::apb_rsp_t    apb_rsp,
	input  nes_pkg::dma_status_t status,
	output nes_pkg::sys_type_e   sys_type
);

	logic access;      // Second phase of a transfer
	logic sel_ctrl;
	logic sel_status;
	logic bad_access;
	logic wr_ctrl;

	assign access     = apb_req.psel && apb_req.penable;
	assign sel_ctrl   = (apb_req.paddr == `NES_APB_CTRL);
	assign sel_status = (apb_req.paddr == `NES_APB_STATUS);

	// Unknown offset, or STATUS written
	assign bad_access = !(sel_ctrl || sel_status) || (sel_status && apb_req.pwrite);
	assign wr_ctrl    = access && apb_req.pwrite && sel_ctrl;

	always_ff @(posedge clk) begin
		if (reset)
			sys_type <= nes_pkg::SYS_NTSC;
		else if (wr_ctrl)
			sys_type <= nes_pkg::sys_type_e'(apb_req.pwdata[1:0]);
	end

	always_comb begin
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = access && bad_access;
		apb_rsp.prdata  = '0;
		if (access && !apb_req.pwrite) begin
			if (sel_ctrl)
				apb_rsp.prdata = {{(`NES_APB_DW - 2){1'b0}}, sys_type};
			else if (sel_status)
				apb_rsp.prdata = {{(`NES_APB_DW - 10){1'b0}}, status};  // Live, not sampled
		end
	end

endmodule

`default_nettype wire

// ==== logic/nes_core_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nes_consts.svh"

module nes_core_bus (
	input  logic                     clk,
	input  logic                     reset,
	input  nes_pkg::apb_req_t        apb_req,
	output nes_pkg::apb_rsp_t        apb_rsp,
	input  nes_pkg::cpu_bus_t        cpu,
	input  logic [`NES_DATA_W-1:0]   mem_din,
	input  logic [`NES_JOY_BITS-1:0] joypad1_data,
	input  logic [`NES_JOY_BITS-1:0] joypad2_data,
	input  logic                     dmc_request,
	input  nes_pkg::bus_addr_u       dmc_addr,
	output nes_pkg::mem_bus_t        mem,
	output logic [`NES_DATA_W-1:0]   from_data_bus,
	output nes_pkg::clk_en_t         clk_en,
	output logic                     pause_cpu,
	output logic                     dmc_ack,
	output logic [2:0]               joypad_out,
	output logic [1:0]               joypad_clock
);

	nes_pkg::sys_type_e   sys_type;
	nes_pkg::dma_status_t dma_status;
	nes_pkg::dma_req_t    dma;
	nes_pkg::bus_addr_u   bus_addr;   // Address of whoever owns the bus
	logic                 bus_write;

	nes_config_regs nes_config_regs_i (
		.clk      (clk),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.status   (dma_status),
		.sys_type (sys_type)
	);

	nes_clock_enables nes_clock_enables_i (
		.clk      (clk),
		.reset    (reset),
		.sys_type (sys_type),
		.ce       (clk_en)
	);

	nes_sprite_dmc_dma nes_sprite_dmc_dma_i (
		.clk           (clk),
		.reset         (reset),
		.ce            (clk_en),
		.bus_addr      (bus_addr),
		.bus_write     (bus_write),
		.cpu_rnw       (cpu.rnw),
		.cpu_dout      (cpu.dout),     // Page byte of the 0x4014 write
		.from_data_bus (from_data_bus),
		.dmc_request   (dmc_request),
		.dmc_addr      (dmc_addr),
		.dma           (dma),
		.pause_cpu     (pause_cpu),
		.dmc_ack       (dmc_ack),
		.status        (dma_status)
	);

	nes_bus_arbiter nes_bus_arbiter_i (
		.clk           (clk),
		.reset         (reset),
		.ce            (clk_en),
		.cpu           (cpu),
		.dma           (dma),
		.mem_din       (mem_din),
		.joypad1_data  (joypad1_data),
		.joypad2_data  (joypad2_data),
		.bus_addr      (bus_addr),
		.bus_write     (bus_write),
		.mem           (mem),
		.from_data_bus (from_data_bus),
		.joypad_out    (joypad_out),
		.joypad_clock  (joypad_clock)
	);

endmodule

`default_nettype wire

// ==== verification/nes_core_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nes_consts.svh"

module nes_core_bus_tb;

	localparam int PLANNED_CYCLES = 20000;  // Clock and register tests plus one full sprite DMA
	localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;
	localparam logic [7:0]  SPR_PAGE  = 8'h03;
	localparam logic [15:0] DMC_ADDR  = 16'hC0DE;
	localparam logic [15:0] HOLD_ADDR = 16'h8000;  // CPU read held while paused

	logic                     clk = 1'b0;
	logic                     reset;
	nes_pkg::apb_req_t        apb_req;
	nes_pkg::apb_rsp_t        apb_rsp;
	nes_pkg::cpu_bus_t        cpu;
	logic [7:0]               mem_din = 8'h00;
	logic [`NES_JOY_BITS-1:0] joypad1_data = '0;
	logic [`NES_JOY_BITS-1:0] joypad2_data = '0;
	logic                     dmc_request;
	nes_pkg::bus_addr_u       dmc_addr;
	nes_pkg::mem_bus_t        mem;
	logic [7:0]               from_data_bus;
	nes_pkg::clk_en_t         clk_en;
	logic                     pause_cpu;
	logic                     dmc_ack;
	logic [2:0]               joypad_out;
	logic [1:0]               joypad_clock;

	logic [16:0] lfsr = 17'd68027;
	logic [7:0]  rnd_byte;
	int          cycle_count = 0;
	int          ce_count = 0;   // CPU cycles seen by the clock monitor
	int          ce_taken = 0;   // CPU cycles already given fresh data
	logic [1:0]  cur_sys = 2'd0;
	int          since_cpu = 0;
	int          since_ppu = 0;
	int          cyc_idx = 0;    // CPU cycles since the last divider restart
	logic        cpu_armed = 1'b0;
	logic        ppu_armed = 1'b0;
	logic        hold_ce = 1'b0;  // Skip enables left over from the old divider
	logic        odd_expect = 1'b1;
	logic        spr_start = 1'b0;
	logic        spr_active = 1'b0;
	logic        spr_done = 1'b0;
	logic        want_write = 1'b0;
	logic [8:0]  spr_count = 9'd0;  // Completed OAM writes
	logic [7:0]  spr_data = 8'h00;
	logic [1:0]  fall_wait = 2'd0;
	logic        idle_cycle = 1'b0;
	int          ack_count = 0;

	nes_core_bus nes_core_bus_i (
		.clk           (clk),
		.reset         (reset),
		.apb_req       (apb_req),
		.apb_rsp       (apb_rsp),
		.cpu           (cpu),
		.mem_din       (mem_din),
		.joypad1_data  (joypad1_data),
		.joypad2_data  (joypad2_data),
		.dmc_request   (dmc_request),
		.dmc_addr      (dmc_addr),
		.mem           (mem),
		.from_data_bus (from_data_bus),
		.clk_en        (clk_en),
		.pause_cpu     (pause_cpu),
		.dmc_ack       (dmc_ack),
		.joypad_out    (joypad_out),
		.joypad_clock  (joypad_clock)
	);

	always #2 clk = ~clk;

	// Fibonacci LFSR x^17 + x^14 + 1, one step per bit
	function automatic logic [7:0] next_random(input int nbits);
		logic [7:0] val;
		logic       fb;
		val = 8'h00;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr[16] ^ lfsr[13];
			lfsr = {lfsr[15:0], fb};
			val = {val[6:0], fb};
		end
		return val;
	endfunction

	// PAL stretches the fifth cycle of each group
	function automatic int cpu_cycle_len(input int idx);
		if (cur_sys == 2'd1 && idx % `NES_PAL_GROUP == `NES_PAL_GROUP - 1)
			return `NES_CPU_DIV + 1;
		return `NES_CPU_DIV;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("mismatch at %0t ns: %s", $time, msg));
	endtask

	task automatic wait_cpu_cycles(input int n);
		repeat (n) begin
			do @(posedge clk); while (!clk_en.cpu_ce);
		end
	endtask

	task automatic wait_dma_writes(input logic [8:0] n);
		while (spr_count < n)
			@(negedge clk);
	endtask

	// Two-cycle APB transfer, response sampled in the access phase
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		input logic exp_err, output logic [31:0] rdata);
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		@(posedge clk);
		assert (apb_rsp.pready) else report_mismatch("pready low");
		assert (apb_rsp.pslverr == exp_err)
			else report_mismatch($sformatf("pslverr %b at offset %h", apb_rsp.pslverr, addr));
		rdata = apb_rsp.prdata;
		@(negedge clk);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	// One CPU cycle, stretched while pause_cpu holds it
	task automatic cpu_cycle(input logic [15:0] addr, input logic rnw, input logic [7:0] dout,
		output logic [7:0] din, output int reads, output logic [1:0] jclk);
		logic done;
		done = 1'b0;
		reads = 0;
		jclk = 2'b00;
		@(negedge clk);
		cpu.addr.word = addr;
		cpu.rnw       = rnw;
		cpu.dout      = dout;
		while (!done) begin
			@(posedge clk);
			if (mem.read)
				reads++;
			jclk = jclk | joypad_clock;
			if (clk_en.cpu_ce && pause_cpu) begin
				reads = 0;  // Only the cycle that completes counts
				jclk = 2'b00;
			end else if (clk_en.cpu_ce) begin
				din = from_data_bus;
				done = 1'b1;
			end
		end
	endtask

	// Clock enable spacing and odd/even order
	always @(posedge clk) begin
		if (!reset) begin
			since_cpu = since_cpu + 1;
			since_ppu = since_ppu + 1;
			// Both dividers restart on the clock after the new type is written
			if (hold_ce) begin
				since_cpu = 0;
				since_ppu = 0;
				cyc_idx = 0;
				cpu_armed = 1'b1;
				ppu_armed = 1'b1;
			end
			if (clk_en.ppu_ce && !hold_ce) begin
				if (ppu_armed) begin
					assert (since_ppu == `NES_PPU_DIV)
						else report_mismatch($sformatf("ppu_ce spacing %0d", since_ppu));
				end
				ppu_armed = 1'b1;
				since_ppu = 0;
			end
			if (clk_en.cpu_ce) begin
				assert (clk_en.odd_cycle == odd_expect) else report_mismatch("odd_cycle out of order");
				odd_expect = ~odd_expect;
				ce_count = ce_count + 1;
				if (!hold_ce) begin
					if (cpu_armed) begin
						assert (since_cpu == cpu_cycle_len(cyc_idx))
							else report_mismatch($sformatf("cpu_ce spacing %0d", since_cpu));
					end
					cpu_armed = 1'b1;
					since_cpu = 0;
					cyc_idx = cyc_idx + 1;
				end
			end
			hold_ce = 1'b0;
			// A new system type is latched on this clock
			if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
				apb_req.paddr == `NES_APB_CTRL && apb_req.pwdata[1:0] != cur_sys) begin
				cur_sys = apb_req.pwdata[1:0];
				hold_ce = 1'b1;
			end
		end
	end

	// Memory and joypads give fresh data once per CPU cycle
	always @(negedge clk) begin
		if (ce_count != ce_taken) begin
			mem_din = next_random(8);
			rnd_byte = next_random(`NES_JOY_BITS);
			joypad1_data = rnd_byte[`NES_JOY_BITS-1:0];
			rnd_byte = next_random(`NES_JOY_BITS);
			joypad2_data = rnd_byte[`NES_JOY_BITS-1:0];
			ce_taken = ce_count;
		end
	end

	// Sprite DMA order and data, DMC slot and the idle cycle after it
	always @(posedge clk) begin
		if (!reset) begin
			if (spr_start && !spr_active && !spr_done)
				spr_active = 1'b1;
			if (spr_active) begin
				assert (pause_cpu) else report_mismatch("pause_cpu low during sprite DMA");
				if (mem.read && mem.addr.paged.page == SPR_PAGE) begin
					assert (!want_write && mem.addr.paged.offset == spr_count[7:0])
						else report_mismatch($sformatf("sprite read of %h", mem.addr.word));
					spr_data = mem_din;
					want_write = 1'b1;
				end
				if (mem.write) begin
					assert (want_write && mem.addr.word == `NES_OAM_DATA_ADDR && mem.dout == spr_data)
						else report_mismatch($sformatf("OAM write %h to %h", mem.dout, mem.addr.word));
					want_write = 1'b0;
					spr_count = spr_count + 9'd1;
					if (spr_count == 9'd256) begin
						spr_active = 1'b0;
						spr_done = 1'b1;
						fall_wait = 2'd1;
					end
				end
			end
			if (fall_wait == 2'd2) begin
				assert (!pause_cpu) else report_mismatch("pause_cpu still high after DMA");
				fall_wait = 2'd0;
			end else if (fall_wait == 2'd1 && clk_en.cpu_ce) begin
				fall_wait = 2'd2;
			end
			if (idle_cycle) begin
				assert (!mem.write && !(mem.read && mem.addr.word != HOLD_ADDR))
					else report_mismatch("DMA strobe in the cycle after dmc_ack");
				if (clk_en.cpu_ce)
					idle_cycle = 1'b0;
			end
			if (dmc_ack) begin
				assert (!clk_en.odd_cycle && mem.addr.word == DMC_ADDR)
					else report_mismatch("dmc_ack on odd cycle or wrong address");
				assert (!clk_en.cart_ce || mem.read) else report_mismatch("no DMC read strobe");
				if (clk_en.cpu_ce) begin
					ack_count = ack_count + 1;
					idle_cycle = 1'b1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout: no result after %0d cycles", cycle_count));
	end

	initial begin
		logic [31:0] rdata;
		logic [7:0]  din;
		logic [7:0]  prev_bus;
		int          reads;
		logic [1:0]  jclk;
		reset         = 1'b1;
		apb_req       = '0;
		cpu.addr.word = HOLD_ADDR;
		cpu.rnw       = 1'b1;
		cpu.dout      = 8'h00;
		dmc_request   = 1'b0;
		dmc_addr.word = DMC_ADDR;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// NTSC spacing, then PAL groups, Dendy and back
		wait_cpu_cycles(30);
		apb_access(1'b1, `NES_APB_CTRL, 32'd1, 1'b0, rdata);
		wait_cpu_cycles(25);
		apb_access(1'b0, `NES_APB_CTRL, 32'd0, 1'b0, rdata);
		assert (rdata == 32'd1) else report_mismatch($sformatf("CTRL reads %h", rdata));
		apb_access(1'b1, `NES_APB_CTRL, 32'd2, 1'b0, rdata);
		wait_cpu_cycles(12);
		apb_access(1'b0, `NES_APB_CTRL, 32'd0, 1'b0, rdata);
		assert (rdata == 32'd2) else report_mismatch($sformatf("CTRL reads %h", rdata));
		apb_access(1'b1, `NES_APB_CTRL, 32'd0, 1'b0, rdata);
		wait_cpu_cycles(12);
		apb_access(1'b0, 8'h08, 32'd0, 1'b1, rdata);            // Unknown offset
		apb_access(1'b1, `NES_APB_STATUS, 32'hFF, 1'b1, rdata);  // Read-only register
		apb_access(1'b0, `NES_APB_STATUS, 32'd0, 1'b0, rdata);
		assert (!rdata[9]) else report_mismatch("sprite_busy while idle");

		// Data bus, open bus and joypads
		wait_cpu_cycles(1);
		cpu_cycle(16'h8000, 1'b1, 8'h00, din, reads, jclk);
		assert (din == mem_din && reads == 1) else report_mismatch("read outside window");
		prev_bus = din;
		cpu_cycle(`NES_JOY1_ADDR, 1'b1, 8'h00, din, reads, jclk);
		assert (din == {prev_bus[7:5], joypad1_data} && jclk == 2'b01 && reads == 0)
			else report_mismatch($sformatf("joypad 1 read %h", din));
		prev_bus = din;
		cpu_cycle(16'h2002, 1'b1, 8'h00, din, reads, jclk);
		assert (din == prev_bus && jclk == 2'b00 && reads == 0)
			else report_mismatch($sformatf("open bus read %h", din));
		cpu_cycle(`NES_JOY2_ADDR, 1'b1, 8'h00, din, reads, jclk);
		assert (din == {prev_bus[7:5], joypad2_data} && jclk == 2'b10)
			else report_mismatch($sformatf("joypad 2 read %h", din));
		cpu_cycle(`NES_JOY1_ADDR, 1'b0, 8'hF5, din, reads, jclk);
		assert (joypad_out == 3'b101) else report_mismatch("joypad strobe latch");
		cpu_cycle(16'h9000, 1'b1, 8'h00, din, reads, jclk);
		assert (din == mem_din && reads == 1) else report_mismatch("read after strobe write");

		// Sprite DMA of one page with a DMC fetch in the middle
		cpu_cycle(`NES_OAM_DMA_ADDR, 1'b0, SPR_PAGE, din, reads, jclk);
		fork
			cpu_cycle(HOLD_ADDR, 1'b1, 8'h00, din, reads, jclk);
			begin
				@(negedge clk);
				spr_start = 1'b1;
				wait_dma_writes(9'd8);
				apb_access(1'b0, `NES_APB_STATUS, 32'd0, 1'b0, rdata);
				// Busy with the written page, no DMC fetch pending yet
				assert (rdata[9:8] == 2'b10 && rdata[7:0] == SPR_PAGE && rdata[31:10] == '0)
					else report_mismatch($sformatf("STATUS reads %h during DMA", rdata));
				wait_dma_writes(9'd40);
				dmc_request = 1'b1;
				do @(posedge clk); while (!dmc_ack);
				@(negedge clk);
				dmc_request = 1'b0;
			end
		join
		@(posedge clk);
		assert (spr_count == 9'd256 && ack_count == 1 && fall_wait == 2'd0)
			else report_mismatch($sformatf("%0d OAM writes, %0d DMC acks", spr_count, ack_count));

		repeat (4) @(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/nes_pkg.sv
logic/nes_clock_enables.sv
logic/nes_sprite_dmc_dma.sv
logic/nes_bus_arbiter.sv
logic/nes_config_regs.sv
logic/nes_core_bus.sv
verification/nes_core_bus_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
	--top-module nes_core_bus_tb --Mdir obj_dir -o nes_core_bus_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/nes_core_bus_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi
exit 0
